// File: src/sift_consts.svh
`ifndef SIFT_CONSTS_SVH
`define SIFT_CONSTS_SVH

// image geometry
`define IMG_W 16
`define IMG_H 16

`define PIX_W 8
`define DOG_W 10   // signed, covers -255..255

// one keypoint entry per pixel at most
`define KPT_DEPTH 256

`define ROW_AW 4
`define KPT_AW 8

`endif

// File: src/sift_pkg.sv
`default_nettype none

`include "sift_consts.svh"

package sift_pkg;

    typedef logic [`PIX_W-1:0] pix_t;

    // column 0 sits in the low bits
    typedef pix_t [`IMG_W-1:0] row_t;

    typedef logic signed [`DOG_W-1:0] dog_t;   // original minus blurred

    typedef struct packed {
        logic [`ROW_AW-1:0] row;
        logic [`ROW_AW-1:0] col;
        dog_t               dog;
    } kpt_t;

    typedef enum logic [1:0] {
        st_idle,
        st_gaussian,
        st_detect,
        st_done
    } state_t;

endpackage

`default_nettype wire

// File: src/row_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "sift_consts.svh"

module row_mem #(
    parameter type T     = logic [`PIX_W-1:0],
    parameter int  DEPTH = `IMG_H,
    parameter int  AW    = `ROW_AW
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] addr,
    input  T              din,
    output T              dout
);

    T mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];   // old data on a write cycle
    end

    a_wr_in_range: assert property (@(posedge clk) we |-> (int'(addr) < DEPTH))
        else $error("row_mem write beyond depth, addr %0d", addr);

endmodule

`default_nettype wire

// File: src/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sift_consts.svh"

module line_buffer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           shift,
    input  logic           fill_zero,
    input  sift_pkg::row_t row_in,
    output sift_pkg::row_t win_top,
    output sift_pkg::row_t win_mid,
    output sift_pkg::row_t win_bot
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_top <= '0;
            win_mid <= '0;
            win_bot <= '0;
        end else if (shift) begin
            win_top <= win_mid;
            win_mid <= win_bot;
            win_bot <= fill_zero ? sift_pkg::row_t'('0) : row_in;   // zero row at bottom border
        end
    end

    a_zero_with_shift: assert property (
        @(posedge clk) disable iff (!rst_n) fill_zero |-> shift
    ) else $error("line_buffer fill_zero without shift");

endmodule

`default_nettype wire

// File: src/gaussian_blur.sv
`timescale 1ns/1ps
`default_nettype none

`include "sift_consts.svh"

module gaussian_blur (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    output logic                done,
    output logic [`ROW_AW-1:0]  img_addr,
    input  sift_pkg::row_t      img_row,
    output logic                blur_we,
    output logic [`ROW_AW-1:0]  blur_addr,
    output sift_pkg::row_t      blur_row
);

    localparam int AW    = `ROW_AW;
    localparam int SUM_W = `PIX_W + 4;   // 16x weight sum
    localparam int LAST  = `IMG_H + 3;   // cycle of the final write

    logic [4:0]     cnt;
    logic           buf_shift;
    logic           buf_zero;
    sift_pkg::row_t win_top;
    sift_pkg::row_t win_mid;
    sift_pkg::row_t win_bot;
    sift_pkg::row_t kernel_row;

    // 1-2-1 along a row, zero outside the image
    function automatic logic [SUM_W-1:0] tap_sum(sift_pkg::row_t r, int c);
        logic [SUM_W-1:0] s;
        s = SUM_W'(r[c]) << 1;
        if (c > 0) begin
            s = s + SUM_W'(r[c-1]);
        end
        if (c < `IMG_W - 1) begin
            s = s + SUM_W'(r[c+1]);
        end
        return s;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!start) begin
            cnt <= '0;
        end else if (cnt != 5'(LAST + 1)) begin
            cnt <= cnt + 5'd1;   // saturates past done
        end
    end

    assign img_addr  = cnt[AW-1:0];   // rows 0..15 on cycles 0..15
    assign buf_shift = start && (cnt >= 5'd1) && (cnt <= 5'(`IMG_H + 1));
    assign buf_zero  = start && (cnt == 5'(`IMG_H + 1));
    assign done      = start && (cnt == 5'(LAST));

    line_buffer u_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (buf_shift),
        .fill_zero (buf_zero),
        .row_in    (img_row),
        .win_top   (win_top),
        .win_mid   (win_mid),
        .win_bot   (win_bot)
    );

    always_comb begin : kernel
        logic [SUM_W-1:0] sum;
        for (int c = 0; c < `IMG_W; c++) begin
            sum = tap_sum(win_top, c) + (tap_sum(win_mid, c) << 1) + tap_sum(win_bot, c);
            kernel_row[c] = sum[SUM_W-1:4];   // /16, truncated
        end
    end

    // window for row r is complete at cnt r+3
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blur_we <= 1'b0;
        end else begin
            blur_we <= start && (cnt >= 5'd3) && (cnt <= 5'(LAST - 1));
        end
    end

    always_ff @(posedge clk) begin
        blur_addr <= AW'(cnt - 5'd3);
        blur_row  <= kernel_row;
    end

endmodule

`default_nettype wire

// File: src/keypoint_detect.sv
`timescale 1ns/1ps
`default_nettype none

`include "sift_consts.svh"

module keypoint_detect (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    output logic                done,
    output logic [`ROW_AW-1:0]  row_addr,
    input  sift_pkg::row_t      img_row,
    input  sift_pkg::row_t      blur_row,
    input  logic                filter_on,
    input  sift_pkg::dog_t      filter_threshold,
    output logic                kpt_we,
    output logic [`KPT_AW-1:0]  kpt_addr,
    output sift_pkg::kpt_t      kpt_din,
    output logic [`KPT_AW:0]    kpt_total
);

    localparam int AW         = `ROW_AW;
    localparam int PHASE_LAST = `IMG_W;   // phase 0 latches, 1..16 walk columns

    logic             running;
    logic [4:0]       phase;
    logic [AW-1:0]    rd_row;
    logic [AW-1:0]    cur_row;
    logic [AW-1:0]    col;
    logic             launch;
    logic             read_phase;
    logic             col_phase;
    logic             last_col;
    logic             is_kpt;
    sift_pkg::row_t   img_lat;
    sift_pkg::row_t   blur_lat;
    sift_pkg::dog_t   dog;

    assign launch     = start && !running && !done;   // first cycle addresses row 0
    assign read_phase = running && (phase == 5'd0);
    assign col_phase  = running && (phase != 5'd0);
    assign col        = AW'(phase - 5'd1);
    assign last_col   = col_phase && (phase == 5'(PHASE_LAST)) && (cur_row == AW'(`IMG_H - 1));

    // next row is already addressed during the last column
    assign row_addr = rd_row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running   <= 1'b0;
            phase     <= '0;
            rd_row    <= '0;
            cur_row   <= '0;
            done      <= 1'b0;
            kpt_total <= '0;
        end else begin
            done <= last_col;
            if (!start) begin
                running   <= 1'b0;
                phase     <= '0;
                rd_row    <= '0;
                kpt_total <= '0;
            end else begin
                if (launch) begin
                    running <= 1'b1;
                end else if (last_col) begin
                    running <= 1'b0;
                end
                if (running) begin
                    phase <= (phase == 5'(PHASE_LAST)) ? 5'd0 : phase + 5'd1;
                end
                if (read_phase) begin
                    cur_row <= rd_row;
                    rd_row  <= rd_row + 1'b1;
                end
                if (kpt_we) begin
                    kpt_total <= kpt_total + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_phase) begin
            img_lat  <= img_row;
            blur_lat <= blur_row;
        end
    end

    always_comb begin
        dog = sift_pkg::dog_t'({{(`DOG_W - `PIX_W){1'b0}}, img_lat[col]})
            - sift_pkg::dog_t'({{(`DOG_W - `PIX_W){1'b0}}, blur_lat[col]});
        if (filter_on) begin
            is_kpt = dog > filter_threshold;
        end else begin
            is_kpt = dog > sift_pkg::dog_t'(0);
        end
    end

    assign kpt_we   = col_phase && is_kpt;
    assign kpt_addr = kpt_total[`KPT_AW-1:0];   // consecutive from 0

    always_comb begin
        kpt_din.row = cur_row;
        kpt_din.col = col;
        kpt_din.dog = dog;
    end

    a_total_bound: assert property (
        @(posedge clk) disable iff (!rst_n) kpt_total <= (`KPT_AW+1)'(`KPT_DEPTH)
    ) else $error("keypoint count beyond memory depth: %0d", kpt_total);

endmodule

`default_nettype wire

// File: src/sift_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sift_consts.svh"

module sift_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                gauss_done,
    input  logic                detect_done,
    input  logic [`KPT_AW:0]    kpt_total,
    input  logic [`ROW_AW-1:0]  host_img_addr,
    input  logic [`KPT_AW-1:0]  host_kpt_addr,
    input  logic [`ROW_AW-1:0]  gauss_img_addr,
    input  logic [`ROW_AW-1:0]  detect_row_addr,
    input  logic [`ROW_AW-1:0]  gauss_blur_addr,
    output logic                gauss_start,
    output logic                detect_start,
    output logic [`ROW_AW-1:0]  img_addr,
    output logic [`ROW_AW-1:0]  blur_addr,
    output logic [`KPT_AW-1:0]  kpt_rd_addr,
    output logic                busy,
    output logic                done,
    output logic [`KPT_AW:0]    kpt_count
);

    sift_pkg::state_t state;
    sift_pkg::state_t next_state;
    logic             run_start;

    assign run_start = start && ((state == sift_pkg::st_idle) || (state == sift_pkg::st_done));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= sift_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            sift_pkg::st_idle:     if (start) next_state = sift_pkg::st_gaussian;
            sift_pkg::st_gaussian: if (gauss_done) next_state = sift_pkg::st_detect;
            sift_pkg::st_detect:   if (detect_done) next_state = sift_pkg::st_done;
            sift_pkg::st_done:     if (start) next_state = sift_pkg::st_gaussian;
            default:               next_state = sift_pkg::st_idle;
        endcase
    end

    assign gauss_start  = (state == sift_pkg::st_gaussian);   // level for the whole stage
    assign detect_start = (state == sift_pkg::st_detect);
    assign busy         = gauss_start || detect_start;
    assign done         = (state == sift_pkg::st_done);

    // memory ports follow the stage that owns them
    always_comb begin
        case (state)
            sift_pkg::st_gaussian: begin
                img_addr    = gauss_img_addr;
                blur_addr   = gauss_blur_addr;
                kpt_rd_addr = host_kpt_addr;
            end
            sift_pkg::st_detect: begin
                img_addr    = detect_row_addr;
                blur_addr   = detect_row_addr;
                kpt_rd_addr = kpt_total[`KPT_AW-1:0];   // write pointer
            end
            default: begin
                img_addr    = host_img_addr;
                blur_addr   = '0;
                kpt_rd_addr = host_kpt_addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kpt_count <= '0;
        end else if (run_start) begin
            kpt_count <= '0;
        end else if (state == sift_pkg::st_detect) begin
            kpt_count <= kpt_total;
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(state) && (state inside {sift_pkg::st_idle, sift_pkg::st_gaussian,
                                             sift_pkg::st_detect, sift_pkg::st_done})
    ) else $error("sift_ctrl illegal state %b", state);

endmodule

`default_nettype wire

// File: src/sift_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "sift_consts.svh"

module sift_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                img_we,
    input  logic [`ROW_AW-1:0]  img_addr,
    input  sift_pkg::row_t      img_din,
    input  logic                filter_on,
    input  sift_pkg::dog_t      filter_threshold,
    input  logic [`KPT_AW-1:0]  kpt_addr,
    output logic                busy,
    output logic                done,
    output logic [`KPT_AW:0]    kpt_count,
    output sift_pkg::kpt_t      kpt_dout
);

    logic                gauss_start;
    logic                gauss_done;
    logic [`ROW_AW-1:0]  gauss_img_addr;
    logic [`ROW_AW-1:0]  gauss_blur_addr;
    logic                blur_we;
    sift_pkg::row_t      blur_din;
    logic                detect_start;
    logic                detect_done;
    logic [`ROW_AW-1:0]  detect_row_addr;
    logic                kpt_we;
    sift_pkg::kpt_t      kpt_din;
    logic [`KPT_AW:0]    kpt_total;
    logic [`ROW_AW-1:0]  img_mem_addr;
    logic [`ROW_AW-1:0]  blur_mem_addr;
    logic [`KPT_AW-1:0]  kpt_mem_addr;
    sift_pkg::row_t      img_dout;
    sift_pkg::row_t      blur_dout;

    sift_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .gauss_done      (gauss_done),
        .detect_done     (detect_done),
        .kpt_total       (kpt_total),
        .host_img_addr   (img_addr),
        .host_kpt_addr   (kpt_addr),
        .gauss_img_addr  (gauss_img_addr),
        .detect_row_addr (detect_row_addr),
        .gauss_blur_addr (gauss_blur_addr),
        .gauss_start     (gauss_start),
        .detect_start    (detect_start),
        .img_addr        (img_mem_addr),
        .blur_addr       (blur_mem_addr),
        .kpt_rd_addr     (kpt_mem_addr),
        .busy            (busy),
        .done            (done),
        .kpt_count       (kpt_count)
    );

    gaussian_blur u_gaussian (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (gauss_start),
        .done      (gauss_done),
        .img_addr  (gauss_img_addr),
        .img_row   (img_dout),
        .blur_we   (blur_we),
        .blur_addr (gauss_blur_addr),
        .blur_row  (blur_din)
    );

    keypoint_detect u_detect (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (detect_start),
        .done             (detect_done),
        .row_addr         (detect_row_addr),
        .img_row          (img_dout),
        .blur_row         (blur_dout),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .kpt_we           (kpt_we),
        .kpt_addr         (),
        .kpt_din          (kpt_din),
        .kpt_total        (kpt_total)
    );

    row_mem #(.T(sift_pkg::row_t), .DEPTH(`IMG_H), .AW(`ROW_AW)) u_img_mem (
        .clk  (clk),
        .we   (img_we),   // host only while idle or done
        .addr (img_mem_addr),
        .din  (img_din),
        .dout (img_dout)
    );

    row_mem #(.T(sift_pkg::row_t), .DEPTH(`IMG_H), .AW(`ROW_AW)) u_blur_mem (
        .clk  (clk),
        .we   (blur_we),
        .addr (blur_mem_addr),
        .din  (blur_din),
        .dout (blur_dout)
    );

    row_mem #(.T(sift_pkg::kpt_t), .DEPTH(`KPT_DEPTH), .AW(`KPT_AW)) u_kpt_mem (
        .clk  (clk),
        .we   (kpt_we),
        .addr (kpt_mem_addr),
        .din  (kpt_din),
        .dout (kpt_dout)
    );

    a_no_host_write_busy: assert property (
        @(posedge clk) disable iff (!rst_n) img_we |-> !busy
    ) else $error("host image write while the core is busy");

endmodule

`default_nettype wire

// File: testbench/tb_sift_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "sift_consts.svh"

module tb_sift_core;

    logic                clk;
    logic                rst_n;
    logic                start;
    logic                img_we;
    logic [`ROW_AW-1:0]  img_addr;
    sift_pkg::row_t      img_din;
    logic                filter_on;
    sift_pkg::dog_t      filter_threshold;
    logic [`KPT_AW-1:0]  kpt_addr;
    logic                busy;
    logic                done;
    logic [`KPT_AW:0]    kpt_count;
    sift_pkg::kpt_t      kpt_dout;

    sift_pkg::pix_t      img [`IMG_H][`IMG_W];   // host copy of the image
    sift_pkg::kpt_t      exp_q [$];
    logic [31:0]         lfsr;
    logic                rd_req;
    logic                rd_req_d;
    sift_pkg::kpt_t      rd_exp;
    sift_pkg::kpt_t      rd_exp_d;
    int                  rd_idx;
    int                  rd_idx_d;
    int                  n_plain;
    int                  n_filt;
    int                  n_flat;
    int                  n_new;

    sift_core uut (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .img_we           (img_we),
        .img_addr         (img_addr),
        .img_din          (img_din),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .kpt_addr         (kpt_addr),
        .busy             (busy),
        .done             (done),
        .kpt_count        (kpt_count),
        .kpt_dout         (kpt_dout)
    );

    always #10 clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_pixel(output sift_pkg::pix_t p);
        p = '0;
        for (int b = 0; b < `PIX_W; b++) begin
            lfsr = lfsr_next(lfsr);
            p = {p[`PIX_W-2:0], lfsr[0]};   // one step per bit
        end
    endtask

    // 1-2-1 by 1-2-1 weights with zero outside and truncating /16
    function automatic int ref_blur(input int r, input int c);
        int sum;
        int wr;
        int wc;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                wr = (dr == 0) ? 2 : 1;
                wc = (dc == 0) ? 2 : 1;
                if (r + dr >= 0 && r + dr < `IMG_H && c + dc >= 0 && c + dc < `IMG_W) begin
                    sum += wr * wc * int'(img[r+dr][c+dc]);
                end
            end
        end
        return sum / 16;
    endfunction

    function automatic void build_expected(input logic fon, input sift_pkg::dog_t thr);
        int             d;
        sift_pkg::kpt_t k;
        exp_q.delete();
        for (int r = 0; r < `IMG_H; r++) begin
            for (int c = 0; c < `IMG_W; c++) begin
                d = int'(img[r][c]) - ref_blur(r, c);
                if ((fon && d > int'(thr)) || (!fon && d > 0)) begin
                    k.row = r[`ROW_AW-1:0];
                    k.col = c[`ROW_AW-1:0];
                    k.dog = sift_pkg::dog_t'(d);
                    exp_q.push_back(k);
                end
            end
        end
    endfunction

    task automatic load_image();
        for (int r = 0; r < `IMG_H; r++) begin
            @(negedge clk);
            img_we   = 1'b1;
            img_addr = r[`ROW_AW-1:0];
            for (int c = 0; c < `IMG_W; c++) begin
                img_din[c] = img[r][c];
            end
        end
        @(negedge clk);
        img_we = 1'b0;
    endtask

    task automatic fill_random();
        for (int r = 0; r < `IMG_H; r++) begin
            for (int c = 0; c < `IMG_W; c++) begin
                rand_pixel(img[r][c]);
            end
        end
    endtask

    task automatic wait_busy();
        int i;
        i = 0;
        while (busy !== 1'b1) begin
            if (i == 10) begin
                fail_now("busy did not rise after the start pulse");
            end
            @(negedge clk);
            i++;
        end
        check_val("done", done, 0);
    endtask

    task automatic wait_done();
        int i;
        i = 0;
        while (done !== 1'b1) begin
            if (i == 2000) begin
                fail_now("done never went high after the run started");
            end
            @(negedge clk);
            i++;
        end
        check_val("busy", busy, 0);
    endtask

    // the checker compares each entry two edges later
    task automatic read_entries();
        for (int i = 0; i < exp_q.size(); i++) begin
            @(negedge clk);
            kpt_addr = i[`KPT_AW-1:0];
            rd_req   = 1'b1;
            rd_exp   = exp_q[i];
            rd_idx   = i;
        end
        @(negedge clk);
        rd_req = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic run_check(input logic fon, input sift_pkg::dog_t thr, output int n);
        @(negedge clk);
        filter_on        = fon;
        filter_threshold = thr;
        build_expected(fon, thr);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_busy();
        wait_done();
        check_val("kpt_count", kpt_count, exp_q.size());
        n = int'(kpt_count);
        read_entries();
    endtask

    always @(posedge clk) begin
        if (rd_req_d) begin
            check_val($sformatf("kpt_dout[%0d]", rd_idx_d), kpt_dout, rd_exp_d);
        end
        rd_req_d <= rd_req;
        rd_exp_d <= rd_exp;
        rd_idx_d <= rd_idx;
    end

    initial begin
        clk              = 1'b0;
        rst_n            = 1'b0;
        start            = 1'b0;
        img_we           = 1'b0;
        img_addr         = '0;
        img_din          = '0;
        filter_on        = 1'b0;
        filter_threshold = '0;
        kpt_addr         = '0;
        rd_req           = 1'b0;
        rd_req_d         = 1'b0;
        rd_exp           = '0;
        rd_idx           = 0;
        lfsr             = 32'hd3b3397b;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_val("busy", busy, 0);
        check_val("done", done, 0);
        check_val("kpt_count", kpt_count, 0);

        fill_random();
        load_image();
        run_check(1'b0, '0, n_plain);
        run_check(1'b1, 10'sd20, n_filt);   // same image with a threshold
        if (n_filt > n_plain) begin
            fail_now("filtered keypoint count is larger than the unfiltered count");
        end

        // only border pixels of a flat image lose energy to zero fill
        for (int r = 0; r < `IMG_H; r++) begin
            for (int c = 0; c < `IMG_W; c++) begin
                img[r][c] = 8'hc8;
            end
        end
        build_expected(1'b0, '0);
        check_val("flat reference count", exp_q.size(), 4 * `IMG_W - 4);
        foreach (exp_q[i]) begin
            check_val("flat reference border", (exp_q[i].row == 0) || (exp_q[i].col == 0)
                      || (exp_q[i].row == `IMG_H - 1) || (exp_q[i].col == `IMG_W - 1), 1);
        end
        load_image();
        run_check(1'b0, '0, n_flat);

        fill_random();
        load_image();
        run_check(1'b0, '0, n_new);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sift_core.f
+incdir+src
src/sift_pkg.sv
src/row_mem.sv
src/line_buffer.sv
src/gaussian_blur.sv
src/keypoint_detect.sv
src/sift_ctrl.sv
src/sift_core.sv
testbench/tb_sift_core.sv
